/* rtl/csr_bus_pkg.sv */
/*
 * APB-side widths, the CSR word and the register map of the subsystem.
 * Addresses are byte addresses of whole 32-bit registers.
 * Only addr_ctrl takes writes; addr_count is read only.
 * Every other address is unmapped and completes with pslverr.
 */

`default_nettype none

package csr_bus_pkg;

	//////////////////////////////
	// widths and types
	//////////////////////////////

	localparam int csr_addr_width = 4; // byte address, 16 bytes of space.
	localparam int csr_word_width = 32;

	typedef logic [csr_addr_width-1:0] csr_addr_t;
	typedef logic [csr_word_width-1:0] csr_word_t; // prdata, pwdata and read payload.

	//////////////////////////////
	// register map
	//////////////////////////////

	localparam csr_addr_t addr_ctrl  = 4'h0; // control word, read and write.
	localparam csr_addr_t addr_count = 4'h4; // event count, read only.

	// an address that decodes to any register may be read.
	function automatic logic csr_readable(input csr_addr_t addr);
		return (addr == addr_ctrl) || (addr == addr_count);
	endfunction

	// only the control register accepts a write.
	function automatic logic csr_writable(input csr_addr_t addr);
		return addr == addr_ctrl;
	endfunction

endpackage

`default_nettype wire

/* rtl/event_pkg.sv */
/*
 * Target-side types of the event counter, which runs on tclk.
 * The count wraps modulo 2^32 and is never saturated.
 * While the clear bit is set the count is held at zero.
 */

`default_nettype none

package event_pkg;

	localparam int ctrl_width  = 2;
	localparam int count_width = 32;

	// control word as it is stored in the target.
	typedef logic [ctrl_width-1:0] ctrl_t;

	// event count, wraps modulo 2^32.
	typedef logic [count_width-1:0] count_t;

	//////////////////////////////
	// control word bits
	//////////////////////////////

	localparam int ctrl_enable_bit = 0; // count sampled events when set.
	localparam int ctrl_clear_bit  = 1; // hold the count at zero when set.

	// the counter comes out of reset disabled and not clearing.
	localparam ctrl_t ctrl_reset = '0;

endpackage

`default_nettype wire

/* rtl/csr_async_read.sv */
/*
 * Toggle-handshake read bridge from cclk into tclk and back.
 * No phase relation between the clocks is assumed.
 * One request may be in flight; the requester waits for rd_done_strobe.
 * The payload bits must all settle within one cclk cycle of each other.
 */

`default_nettype none

module csr_async_read #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     cclk,
	input  logic     tclk,
	input  logic     rst_b_cclk,
	input  logic     rst_b_tclk,
	input  logic     rd_strobe,      // one cclk cycle, starts a read.
	input  payload_t rd_data_tclk,   // value the target presents in tclk.
	output payload_t rd_data,        // sampled value, back in cclk.
	output logic     rd_wait,
	output logic     rd_done_strobe,
	output logic     rd_strobe_tclk  // one tclk cycle, marks the latch edge.
);

	logic     req_cclk;       // request toggle, flips once per read.
	logic     ack_s1_cclk;    // first stage on the echo.
	logic     ack_cclk;       // echo after two stages.
	logic     ack_dly_cclk;   // echo after the extra settling stage.
	logic     rd_wait_dly;
	payload_t data_s1_cclk;
	payload_t data_cclk;

	logic     req_s1_tclk;
	logic     req_sync_tclk;
	logic     ack_tclk;       // echo toggle, follows the request once served.
	payload_t data_l_tclk;    // value held for the cclk side to pick up.

	//////////////////////////////
	// cclk side
	//////////////////////////////

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			req_cclk     <= 1'b0;
			ack_s1_cclk  <= 1'b0;
			ack_cclk     <= 1'b0;
			ack_dly_cclk <= 1'b0;
			rd_wait_dly  <= 1'b0;
			data_s1_cclk <= '0;
			data_cclk    <= '0;
		end else begin
			ack_s1_cclk  <= ack_tclk;
			ack_cclk     <= ack_s1_cclk;
			ack_dly_cclk <= ack_cclk; // data stages have caught up by this point.
			rd_wait_dly  <= rd_wait;
			data_s1_cclk <= data_l_tclk;
			data_cclk    <= data_s1_cclk;
			if (rd_strobe)
				req_cclk <= ~req_cclk;
		end
	end

	// the strobe itself counts as waiting, so rd_wait rises in its own cycle.
	always_comb begin
		rd_wait        = rd_strobe || (req_cclk != ack_dly_cclk);
		rd_done_strobe = !rd_wait && rd_wait_dly; // falling edge of rd_wait.
		rd_data        = data_cclk;
	end

	//////////////////////////////
	// tclk side
	//////////////////////////////

	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			req_s1_tclk    <= 1'b0;
			req_sync_tclk  <= 1'b0;
			ack_tclk       <= 1'b0;
			rd_strobe_tclk <= 1'b0;
			data_l_tclk    <= '0;
		end else begin
			req_s1_tclk   <= req_cclk;
			req_sync_tclk <= req_s1_tclk;
			if (req_sync_tclk != ack_tclk) begin
				ack_tclk       <= req_sync_tclk; // echo the toggle.
				rd_strobe_tclk <= 1'b1;
				data_l_tclk    <= rd_data_tclk;  // latch on the same edge.
			end else begin
				rd_strobe_tclk <= 1'b0;
			end
		end
	end

	// a new read may only start once the echo of the last one is home.
	a_no_overlap: assert property (@(posedge cclk) disable iff (!rst_b_cclk)
		rd_strobe |-> (req_cclk == ack_dly_cclk));

endmodule

`default_nettype wire

/* rtl/csr_async_write.sv */
/*
 * Toggle-handshake write bridge that carries a payload from cclk into tclk.
 * The payload is held in cclk registers until tclk has acknowledged it.
 * One write may be in flight; the requester waits for wr_done_strobe.
 * No phase relation between the clocks is assumed.
 */

`default_nettype none

module csr_async_write #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     cclk,
	input  logic     tclk,
	input  logic     rst_b_cclk,
	input  logic     rst_b_tclk,
	input  logic     wr_strobe,        // one cclk cycle, starts a write.
	input  payload_t wr_payload,       // valid with wr_strobe only.
	output logic     wr_wait,
	output logic     wr_done_strobe,
	output logic     wr_strobe_tclk,   // one tclk cycle, payload is valid.
	output payload_t wr_payload_tclk
);

	logic     req_cclk;          // request toggle.
	payload_t payload_hold_cclk; // stays put while the write is in flight.
	logic     ack_s1_cclk;
	logic     ack_cclk;
	logic     wr_wait_dly;

	logic     req_s1_tclk;
	logic     req_sync_tclk;
	logic     ack_tclk;          // echo toggle.

	//////////////////////////////
	// cclk side
	//////////////////////////////

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			req_cclk    <= 1'b0;
			ack_s1_cclk <= 1'b0;
			ack_cclk    <= 1'b0;
			wr_wait_dly <= 1'b0;
		end else begin
			ack_s1_cclk <= ack_tclk;
			ack_cclk    <= ack_s1_cclk;
			wr_wait_dly <= wr_wait;
			if (wr_strobe)
				req_cclk <= ~req_cclk;
		end
	end

	always_ff @(posedge cclk) begin
		if (wr_strobe)
			payload_hold_cclk <= wr_payload; // captured with the toggle.
	end

	always_comb begin
		wr_wait        = wr_strobe || (req_cclk != ack_cclk);
		wr_done_strobe = !wr_wait && wr_wait_dly; // falling edge of wr_wait.
	end

	//////////////////////////////
	// tclk side
	//////////////////////////////

	// the held payload has been stable for two tclk edges when the toggle shows.
	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			req_s1_tclk     <= 1'b0;
			req_sync_tclk   <= 1'b0;
			ack_tclk        <= 1'b0;
			wr_strobe_tclk  <= 1'b0;
			wr_payload_tclk <= '0;
		end else begin
			req_s1_tclk   <= req_cclk;
			req_sync_tclk <= req_s1_tclk;
			if (req_sync_tclk != ack_tclk) begin
				ack_tclk        <= req_sync_tclk;
				wr_strobe_tclk  <= 1'b1;
				wr_payload_tclk <= payload_hold_cclk;
			end else begin
				wr_strobe_tclk <= 1'b0;
			end
		end
	end

	// the hold register must not change under a write in flight.
	a_no_overlap: assert property (@(posedge cclk) disable iff (!rst_b_cclk)
		wr_strobe |-> (req_cclk == ack_cclk));

endmodule

`default_nettype wire

/* rtl/apb_csr_port.sv */
/*
 * APB completer for the CSR map, clocked on cclk.
 * Mapped accesses wait on the read or write bridge with pready low.
 * Unmapped accesses and writes to the count complete in the first access
 * cycle with pslverr. No burst or pipelined access is supported.
 */

`default_nettype none

module apb_csr_port (
	input  logic                  cclk,
	input  logic                  rst_b_cclk,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  csr_bus_pkg::csr_addr_t paddr,
	input  csr_bus_pkg::csr_word_t pwdata,
	input  csr_bus_pkg::csr_word_t rd_data,        // from the read bridge.
	input  logic                  rd_done_strobe,
	input  logic                  wr_done_strobe,
	output csr_bus_pkg::csr_word_t prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  rd_strobe,
	output logic                  wr_strobe,
	output event_pkg::ctrl_t      wr_payload,
	output csr_bus_pkg::csr_addr_t csr_addr         // read select in tclk.
);

	import csr_bus_pkg::*;
	import event_pkg::*;

	typedef enum logic [1:0] {st_idle, st_wait_rd, st_wait_wr} port_state_t;

	port_state_t state;
	logic        setup;  // first cycle of a transfer.
	logic        access; // access phase while no bridge transfer is running.

	always_comb begin
		setup      = psel && !penable && (state == st_idle);
		access     = psel && penable && (state == st_idle); // only error accesses.
		rd_strobe  = setup && !pwrite && csr_readable(paddr);
		wr_strobe  = setup && pwrite && csr_writable(paddr);
		wr_payload = ctrl_t'(pwdata[$bits(ctrl_t)-1:0]); // upper bits are dropped.
	end

	//////////////////////////////
	// state and address
	//////////////////////////////

	always_ff @(posedge cclk) begin
		if (!rst_b_cclk) begin
			state    <= st_idle;
			csr_addr <= '0;
		end else begin
			if (setup)
				csr_addr <= paddr; // held until the next transfer starts.
			case (state)
				st_idle: begin
					if (rd_strobe)
						state <= st_wait_rd;
					else if (wr_strobe)
						state <= st_wait_wr;
				end
				st_wait_rd: if (rd_done_strobe) state <= st_idle;
				st_wait_wr: if (wr_done_strobe) state <= st_idle;
				default:    state <= st_idle;
			endcase
		end
	end

	// completion is combinational on the done strobes.
	always_comb begin
		pready  = access || (state == st_wait_rd && rd_done_strobe) ||
		          (state == st_wait_wr && wr_done_strobe);
		pslverr = access;
		prdata  = (state == st_wait_rd && rd_done_strobe) ? rd_data : '0;
	end

	a_penable_psel: assert property (@(posedge cclk) disable iff (!rst_b_cclk)
		penable |-> psel);

endmodule

`default_nettype wire

/* rtl/event_counter.sv */
/*
 * Event counter in the tclk domain with its control register.
 * event_pulse must be synchronous to tclk; each sampled cycle counts once.
 * csr_addr comes from cclk and is only sampled by the read bridge latch.
 */

`default_nettype none

module event_counter (
	input  logic                   tclk,
	input  logic                   rst_b_tclk,
	input  logic                   event_pulse,
	input  logic                   wr_strobe_tclk,
	input  event_pkg::ctrl_t       wr_payload_tclk,
	input  csr_bus_pkg::csr_addr_t csr_addr,
	output csr_bus_pkg::csr_word_t rd_data_tclk
);

	import csr_bus_pkg::*;
	import event_pkg::*;

	ctrl_t  ctrl;  // enable and clear bits.
	count_t count;

	//////////////////////////////
	// control and count
	//////////////////////////////

	always_ff @(posedge tclk) begin
		if (!rst_b_tclk) begin
			ctrl  <= ctrl_reset;
			count <= '0;
		end else begin
			if (wr_strobe_tclk)
				ctrl <= wr_payload_tclk; // a write replaces the whole word.
			if (ctrl[ctrl_clear_bit])
				count <= '0; // clear wins over enable.
			else if (event_pulse && ctrl[ctrl_enable_bit])
				count <= count + count_t'(1); // wraps at 2^32.
		end
	end

	// read select, decoded from the address the port holds steady.
	always_comb begin
		case (csr_addr)
			addr_ctrl:  rd_data_tclk = csr_word_t'(ctrl);
			addr_count: rd_data_tclk = csr_word_t'(count);
			default:    rd_data_tclk = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/csr_subsystem.sv */
/*
 * Clock-crossing CSR subsystem: APB on cclk, event counter on tclk.
 * The two clocks may be fully unrelated; each has its own reset.
 * One transfer at a time, completed by pready.
 */

`default_nettype none

module csr_subsystem (
	input  logic                   cclk,
	input  logic                   rst_b_cclk,
	input  logic                   tclk,
	input  logic                   rst_b_tclk,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  csr_bus_pkg::csr_addr_t paddr,
	input  csr_bus_pkg::csr_word_t pwdata,
	output csr_bus_pkg::csr_word_t prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   event_pulse      // synchronous to tclk.
);

	import csr_bus_pkg::*;
	import event_pkg::*;

	csr_addr_t csr_addr;
	logic      rd_strobe;
	logic      rd_done_strobe;
	csr_word_t rd_data;
	csr_word_t rd_data_tclk;
	logic      wr_strobe;
	logic      wr_done_strobe;
	ctrl_t     wr_payload;
	ctrl_t     wr_payload_tclk;
	logic      wr_strobe_tclk;

	//////////////////////////////
	// cclk side
	//////////////////////////////

	apb_csr_port i_port (
		.cclk(cclk), .rst_b_cclk(rst_b_cclk),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.rd_data(rd_data), .rd_done_strobe(rd_done_strobe),
		.wr_done_strobe(wr_done_strobe),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.rd_strobe(rd_strobe), .wr_strobe(wr_strobe),
		.wr_payload(wr_payload), .csr_addr(csr_addr)
	);

	//////////////////////////////
	// bridges
	//////////////////////////////

	csr_async_read #(.payload_t(csr_word_t)) i_rd_bridge (
		.cclk(cclk), .tclk(tclk),
		.rst_b_cclk(rst_b_cclk), .rst_b_tclk(rst_b_tclk),
		.rd_strobe(rd_strobe), .rd_data_tclk(rd_data_tclk),
		.rd_data(rd_data), .rd_wait(), // the port tracks its own state.
		.rd_done_strobe(rd_done_strobe), .rd_strobe_tclk()
	);

	csr_async_write #(.payload_t(ctrl_t)) i_wr_bridge (
		.cclk(cclk), .tclk(tclk),
		.rst_b_cclk(rst_b_cclk), .rst_b_tclk(rst_b_tclk),
		.wr_strobe(wr_strobe), .wr_payload(wr_payload),
		.wr_wait(), .wr_done_strobe(wr_done_strobe),
		.wr_strobe_tclk(wr_strobe_tclk), .wr_payload_tclk(wr_payload_tclk)
	);

	// target block, entirely in tclk.
	event_counter i_counter (
		.tclk(tclk), .rst_b_tclk(rst_b_tclk),
		.event_pulse(event_pulse),
		.wr_strobe_tclk(wr_strobe_tclk), .wr_payload_tclk(wr_payload_tclk),
		.csr_addr(csr_addr), .rd_data_tclk(rd_data_tclk)
	);

endmodule

`default_nettype wire

/* testbench/tb_csr_subsystem.sv */
/*
 * Testbench for the clock-crossing CSR subsystem.
 * cclk and tclk run at unrelated periods, so bridge latency varies per transfer.
 * Events are only driven once a control write has settled in tclk, and a count
 * is only read once the last event has settled.
 */

`default_nettype none

module tb_csr_subsystem;

	import csr_bus_pkg::*;
	import event_pkg::*;

	localparam int cclk_period   = 8;
	localparam int tclk_period   = 14;
	localparam int num_transfers = 40;  // upper bound on the APB transfers below.
	localparam int max_events    = 160; // four bursts of at most 40 pulses.
	localparam int watchdog_time =
		20 * (num_transfers * 60 * cclk_period + max_events * 2 * tclk_period);

	logic      cclk;
	logic      tclk;
	logic      rst_b_cclk;
	logic      rst_b_tclk;
	logic      psel;
	logic      penable;
	logic      pwrite;
	csr_addr_t paddr;
	csr_word_t pwdata;
	csr_word_t prdata;
	logic      pready;
	logic      pslverr;
	logic      event_pulse;

	ctrl_t     model_ctrl;  // settled control word as the target holds it.
	count_t    model_count; // expected event count.
	integer    seed = 32'ha3f9;
	csr_word_t exp_word;
	logic      exp_err;
	logic      setup_seen;  // the previous cclk edge sampled a setup cycle.

	csr_subsystem i_dut (
		.cclk(cclk), .rst_b_cclk(rst_b_cclk),
		.tclk(tclk), .rst_b_tclk(rst_b_tclk),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.event_pulse(event_pulse)
	);

	initial begin
		cclk = 1'b0;
		forever #(cclk_period / 2) cclk = ~cclk;
	end

	initial begin
		tclk = 1'b0;
		forever #(tclk_period / 2) tclk = ~tclk; // no fixed phase to cclk.
	end

	//////////////////////////////
	// reference model
	//////////////////////////////

	// read data and error as the register map defines them.
	function automatic csr_word_t expected_read(input csr_addr_t addr, input ctrl_t ctrl,
		input count_t count, output logic err);
		csr_word_t word;
		err  = 1'b0;
		word = '0;
		if (addr == addr_ctrl)
			word = {{(32 - $bits(ctrl_t)){1'b0}}, ctrl}; // zero-extended.
		else if (addr == addr_count)
			word = count;
		else
			err = 1'b1; // unmapped reads return zero.
		return word;
	endfunction

	// only the control register takes a write.
	function automatic logic expected_write_err(input csr_addr_t addr);
		return addr != addr_ctrl;
	endfunction

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	task automatic check_err(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "wrong value on %s", name);
		end
	endtask

	// every completed transfer is checked at the edge that samples pready.
	always @(posedge cclk) begin
		if (rst_b_cclk && !psel) begin
			check_err("pready", pready, 1'b0); // nothing completes while the bus is idle.
			check_err("pslverr", pslverr, 1'b0);
		end
		if (rst_b_cclk && psel && penable && setup_seen) begin
			if (pwrite)
				exp_err = expected_write_err(paddr);
			else
				exp_word = expected_read(paddr, model_ctrl, model_count, exp_err);
			check_err("pready", pready, exp_err); // only errors complete at once.
		end
		if (rst_b_cclk && psel && penable && pready) begin
			if (pwrite) begin
				exp_err = expected_write_err(paddr);
				check_err("pslverr", pslverr, exp_err);
				if (exp_err)
					check_word("prdata", prdata, '0); // error writes return zero.
			end else begin
				exp_word = expected_read(paddr, model_ctrl, model_count, exp_err);
				check_err("pslverr", pslverr, exp_err);
				if (paddr == addr_ctrl)
					check_ctrl("prdata[1:0]", prdata[1:0], model_ctrl);
				check_word("prdata", prdata, exp_word);
			end
		end
		setup_seen = psel && !penable;
	end

	//////////////////////////////
	// drivers
	//////////////////////////////

	// starts on a falling cclk edge and ends on one, so transfers can follow back to back.
	task automatic apb_read(input csr_addr_t addr);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		pwdata  = '0;
		@(negedge cclk);
		penable = 1'b1;
		@(posedge cclk);
		while (!pready)
			@(posedge cclk);
		@(negedge cclk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input csr_addr_t addr, input csr_word_t data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge cclk);
		penable = 1'b1;
		@(posedge cclk);
		while (!pready)
			@(posedge cclk);
		@(negedge cclk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// waits out tclk cycles, then realigns to a falling cclk edge.
	task automatic settle_tclk(input int cycles);
		repeat (cycles) @(negedge tclk);
		@(negedge cclk);
	endtask

	task automatic write_ctrl(input csr_word_t data);
		apb_write(addr_ctrl, data);
		model_ctrl = data[1:0]; // only the two control bits are stored.
		if (model_ctrl[ctrl_clear_bit])
			model_count = '0;
		settle_tclk(5);
	endtask

	// single-cycle pulses with a random gap of zero to two tclk cycles.
	task automatic drive_events(input int num);
		for (int i = 0; i < num; i++) begin
			@(negedge tclk);
			event_pulse = 1'b1;
			if (model_ctrl[ctrl_enable_bit] && !model_ctrl[ctrl_clear_bit])
				model_count = model_count + 1;
			@(negedge tclk);
			event_pulse = 1'b0;
			repeat ($unsigned($random(seed)) % 3) @(negedge tclk);
		end
		settle_tclk(5);
	endtask

	initial begin
		#(watchdog_time);
		$display("error: watchdog expired, an APB transfer never completed");
		$display("=== FAIL ===");
		$fatal(1, "timeout");
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		int n;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		event_pulse = 1'b0;
		rst_b_cclk  = 1'b0;
		rst_b_tclk  = 1'b0;
		model_ctrl  = ctrl_reset;
		model_count = '0;
		fork
			begin
				repeat (4) @(negedge cclk);
				rst_b_cclk = 1'b1;
			end
			begin
				repeat (4) @(negedge tclk);
				rst_b_tclk = 1'b1;
			end
		join
		settle_tclk(2);

		apb_read(addr_ctrl); // both registers come out of reset at zero.
		apb_read(addr_count);

		for (int i = 0; i < 4; i++) begin
			write_ctrl($random(seed)); // upper bits must be dropped.
			apb_read(addr_ctrl);
		end

		write_ctrl(32'h1); // enable only.
		n = ($unsigned($random(seed)) % 40) + 1;
		drive_events(n);
		apb_read(addr_count);

		write_ctrl(32'h0); // disabled, the count must hold.
		drive_events(($unsigned($random(seed)) % 40) + 1);
		apb_read(addr_count);
		write_ctrl(32'h3); // clear wins over enable.
		apb_read(addr_count);
		drive_events(($unsigned($random(seed)) % 40) + 1);
		apb_read(addr_count);
		write_ctrl(32'h1); // counting resumes from zero.
		apb_read(addr_ctrl);
		drive_events(($unsigned($random(seed)) % 40) + 1);
		apb_read(addr_count);

		apb_read(4'h8); // unmapped accesses and a write to the count.
		apb_write(4'hc, 32'hffff_ffff);
		apb_write(addr_count, 32'h0000_0000);
		apb_read(4'h2);
		apb_read(addr_ctrl);
		apb_read(addr_count);

		for (int i = 0; i < 6; i++) begin
			if (i % 2 == 0)
				apb_read(addr_ctrl);
			else
				apb_read(addr_count);
		end

		settle_tclk(2);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
rtl/csr_bus_pkg.sv
rtl/event_pkg.sv
rtl/csr_async_read.sv
rtl/csr_async_write.sv
rtl/apb_csr_port.sv
rtl/event_counter.sv
rtl/csr_subsystem.sv
testbench/tb_csr_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module tb_csr_subsystem \
	-f project.f \
	-o sim_csr_subsystem

./obj_dir/sim_csr_subsystem
